/* hw/noc_axi_pkg.sv */
/*
  Shared widths, address map and channel types of the NoC AXI slave front end
  Only full-width INCR bursts are accepted (size code FULL_SIZE)
  Each virtual channel owns one 8-byte slot in the transmit and receive windows
  Any address outside those slots decodes as unmapped
*/
package noc_axi_pkg;

  // **************************************************
  // Widths and sizes
  // **************************************************
  localparam int AXI_DATA_WIDTH = 64;
  localparam int AXI_ADDR_WIDTH = 16;
  localparam int AXI_ID_WIDTH   = 4;
  localparam int AXI_LEN_WIDTH  = 8;
  localparam int N_VIRT_CHN     = 3;
  localparam int VC_WIDTH       = 2;
  localparam int RX_BUFF_SLOTS  = 8;
  localparam int MAX_OUTSTD_RD  = 4;

  typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
  typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;
  typedef logic [AXI_LEN_WIDTH-1:0]  axi_len_t;
  typedef logic [VC_WIDTH-1:0]       vc_id_t;

  // Address map
  localparam axi_addr_t  WR_BASE   = 16'h1000;
  localparam axi_addr_t  RD_BASE   = 16'h2000;
  localparam axi_addr_t  VC_STRIDE = 16'd8;
  localparam logic [2:0] FULL_SIZE = 3'd3;

  // **************************************************
  // Encodings
  // **************************************************
  typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10} aresp_t;
  typedef enum logic [1:0] {FIXED = 2'b00, INCR = 2'b01, WRAP = 2'b10} burst_t;
  typedef enum logic [1:0] {NONE, NOC_WR_FIFOS, NOC_RD_FIFOS} mm_region_t;
  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

  // **************************************************
  // Channel payloads, valid bit included
  // **************************************************
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    logic [2:0] size;
    burst_t     burst;
    logic       valid;
  } axi_aw_t;

  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    logic [2:0] size;
    burst_t     burst;
    logic       valid;
  } axi_ar_t;

  typedef struct packed {
    axi_data_t data;
    logic      last;
    logic      valid;
  } axi_w_t;

  typedef struct packed {
    axi_id_t id;
    aresp_t  resp;
    logic    valid;
  } axi_b_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    aresp_t    resp;
    logic      last;
    logic      valid;
  } axi_r_t;

  // Flit towards the packet generator, pkt_sz is beats per burst
  typedef struct packed {
    logic                   valid;
    vc_id_t                 vc;
    logic                   req_new;
    logic                   req_last;
    logic [AXI_LEN_WIDTH:0] pkt_sz;
    axi_data_t              data;
  } pkt_out_t;

  typedef struct packed {
    logic      valid;
    vc_id_t    vc;
    axi_data_t data;
  } pkt_in_t;

  // One entry of the outstanding read queue
  typedef struct packed {
    axi_id_t  id;
    vc_id_t   vc;
    axi_len_t len;
    logic     err;
  } rd_req_t;

  // Region of a full address, exact channel slots only
  function automatic mm_region_t addr_region(axi_addr_t addr);
    mm_region_t region;
    region = NONE;
    for (int k = 0; k < N_VIRT_CHN; k++) begin
      if (addr == WR_BASE + axi_addr_t'(k) * VC_STRIDE)
        region = NOC_WR_FIFOS;
      if (addr == RD_BASE + axi_addr_t'(k) * VC_STRIDE)
        region = NOC_RD_FIFOS;
    end
    return region;
  endfunction

  // Channel index of a mapped address, zero when unmapped
  function automatic vc_id_t addr_vc(axi_addr_t addr);
    vc_id_t vc;
    vc = '0;
    for (int k = 0; k < N_VIRT_CHN; k++) begin
      if ((addr == WR_BASE + axi_addr_t'(k) * VC_STRIDE) ||
          (addr == RD_BASE + axi_addr_t'(k) * VC_STRIDE))
        vc = vc_id_t'(k);
    end
    return vc;
  endfunction

endpackage

/* hw/sync_fifo.sv */
/*
  First-word-fall-through FIFO, head entry is visible on data_o
  SLOTS must be a power of two and at least 2
  Writes when full and reads when empty are ignored
*/
module sync_fifo #(
  parameter int SLOTS = 8,
  parameter int WIDTH = 64
) (
  input  logic             clk_axi,
  input  logic             arst_axi,
  input  logic             write_i,
  input  logic             read_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);
  localparam int PTR_W = $clog2(SLOTS);

  logic [WIDTH-1:0] mem [SLOTS];
  // Extra MSB tells full from empty when the indexes match
  logic [PTR_W:0]   wr_ptr;
  logic [PTR_W:0]   rd_ptr;
  logic             do_wr;
  logic             do_rd;

  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign do_wr   = write_i && !full_o;
  assign do_rd   = read_i && !empty_o;
  assign data_o  = mem[rd_ptr[PTR_W-1:0]];

  // Pointers
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk_axi) begin
    if (do_wr)
      mem[wr_ptr[PTR_W-1:0]] <= data_i;
  end

endmodule

/* hw/axi_wr_path.sv */
/*
  AXI write path, one burst at a time, awready low until B completes
  Each W beat goes out combinationally as a flit, wready follows the generator
  Bad burst type, size or address gives SLVERR, W beats are still absorbed
*/
module axi_wr_path (
  input  logic                  clk_axi,
  input  logic                  arst_axi,
  input  noc_axi_pkg::axi_aw_t  aw_i,
  output logic                  awready_o,
  input  noc_axi_pkg::axi_w_t   w_i,
  output logic                  wready_o,
  output noc_axi_pkg::axi_b_t   b_o,
  input  logic                  bready_i,
  output noc_axi_pkg::pkt_out_t pkt_out_o,
  input  logic                  pkt_out_ready_i
);
  noc_axi_pkg::wr_state_t state_q;
  noc_axi_pkg::wr_state_t state_d;
  noc_axi_pkg::axi_id_t   id_q;
  noc_axi_pkg::vc_id_t    vc_q;
  noc_axi_pkg::axi_len_t  len_q;
  logic                   err_q;
  logic                   head_q;
  logic                   aw_err;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   b_hs;

  // **************************************************
  // Address channel
  // **************************************************
  // Only full-width INCR bursts into the transmit window pass
  assign aw_err = (aw_i.burst != noc_axi_pkg::INCR) ||
                  (aw_i.size != noc_axi_pkg::FULL_SIZE) ||
                  (noc_axi_pkg::addr_region(aw_i.addr) != noc_axi_pkg::NOC_WR_FIFOS);

  assign awready_o = (state_q == noc_axi_pkg::WR_IDLE);
  assign aw_hs     = aw_i.valid && awready_o;

  // **************************************************
  // Data channel and flit out
  // **************************************************
  // Error bursts are sunk here, the generator never sees them
  assign wready_o = (state_q == noc_axi_pkg::WR_DATA) && (err_q || pkt_out_ready_i);
  assign w_hs     = w_i.valid && wready_o;

  always_comb begin
    pkt_out_o.valid    = (state_q == noc_axi_pkg::WR_DATA) && !err_q && w_i.valid;
    pkt_out_o.vc       = vc_q;
    // Head mark on the first beat only
    pkt_out_o.req_new  = head_q;
    pkt_out_o.req_last = w_i.last;
    pkt_out_o.pkt_sz   = {1'b0, len_q} + 1'b1;
    pkt_out_o.data     = w_i.data;
  end

  // Write response
  always_comb begin
    b_o.valid = (state_q == noc_axi_pkg::WR_RESP);
    b_o.id    = id_q;
    b_o.resp  = err_q ? noc_axi_pkg::SLVERR : noc_axi_pkg::OKAY;
  end

  assign b_hs = b_o.valid && bready_i;

  // **************************************************
  // Burst FSM
  // **************************************************
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      noc_axi_pkg::WR_IDLE:
        if (aw_hs)
          state_d = noc_axi_pkg::WR_DATA;
      noc_axi_pkg::WR_DATA:
        // Leave on the wlast handshake, bvalid rises next cycle
        if (w_hs && w_i.last)
          state_d = noc_axi_pkg::WR_RESP;
      noc_axi_pkg::WR_RESP:
        if (b_hs)
          state_d = noc_axi_pkg::WR_IDLE;
      default:
        state_d = noc_axi_pkg::WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      state_q <= noc_axi_pkg::WR_IDLE;
      head_q  <= 1'b1;
    end else begin
      state_q <= state_d;
      if (aw_hs)
        head_q <= 1'b1;
      else if (w_hs)
        head_q <= 1'b0;
    end
  end

  // Burst attributes, captured at AW
  always_ff @(posedge clk_axi) begin
    if (aw_hs) begin
      id_q  <= aw_i.id;
      vc_q  <= noc_axi_pkg::addr_vc(aw_i.addr);
      len_q <= aw_i.len;
      err_q <= aw_err;
    end
  end

endmodule

/* hw/rx_vc_buffers.sv */
/*
  One receive FIFO per virtual channel, filled from the network input
  A flit naming a channel index outside N_VIRT_CHN is never accepted
  The read path selects one channel head and pops it on an R handshake
*/
module rx_vc_buffers (
  input  logic                               clk_axi,
  input  logic                               arst_axi,
  input  noc_axi_pkg::pkt_in_t               pkt_in_i,
  output logic                               pkt_in_ready_o,
  input  noc_axi_pkg::vc_id_t                sel_vc_i,
  input  logic                               pop_i,
  output noc_axi_pkg::axi_data_t             flit_o,
  output logic [noc_axi_pkg::N_VIRT_CHN-1:0] empty_o
);
  logic [noc_axi_pkg::N_VIRT_CHN-1:0] full;
  logic [noc_axi_pkg::N_VIRT_CHN-1:0] push;
  logic [noc_axi_pkg::N_VIRT_CHN-1:0] pop;
  noc_axi_pkg::axi_data_t             head [noc_axi_pkg::N_VIRT_CHN];

  // Input ready from the addressed buffer, output mux on the selected head
  always_comb begin
    pkt_in_ready_o = 1'b0;
    flit_o         = head[0];
    for (int i = 0; i < noc_axi_pkg::N_VIRT_CHN; i++) begin
      if (pkt_in_i.vc == noc_axi_pkg::vc_id_t'(i))
        pkt_in_ready_o = !full[i];
      if (sel_vc_i == noc_axi_pkg::vc_id_t'(i))
        flit_o = head[i];
    end
  end

  // **************************************************
  // Channel buffers
  // **************************************************
  for (genvar g = 0; g < noc_axi_pkg::N_VIRT_CHN; g++) begin : g_vc
    // Demux by channel id, pop only the selected channel
    assign push[g] = pkt_in_i.valid && (pkt_in_i.vc == noc_axi_pkg::vc_id_t'(g)) && !full[g];
    assign pop[g]  = pop_i && (sel_vc_i == noc_axi_pkg::vc_id_t'(g));

    sync_fifo #(
      .SLOTS (noc_axi_pkg::RX_BUFF_SLOTS),
      .WIDTH (noc_axi_pkg::AXI_DATA_WIDTH)
    ) u_vc_fifo (
      .clk_axi  (clk_axi),
      .arst_axi (arst_axi),
      .write_i  (push[g]),
      .read_i   (pop[g]),
      .data_i   (pkt_in_i.data),
      .data_o   (head[g]),
      .full_o   (full[g]),
      .empty_o  (empty_o[g])
    );
  end

endmodule

/* hw/axi_rd_path.sv */
/*
  AXI read path with a queue of up to MAX_OUTSTD_RD requests
  Channel emptiness is checked when the AR is accepted, not when it is served
  An error request returns a single zero beat with SLVERR and rlast
  Valid requests wait on the channel buffer, so beat latency is not fixed
*/
module axi_rd_path (
  input  logic                               clk_axi,
  input  logic                               arst_axi,
  input  noc_axi_pkg::axi_ar_t               ar_i,
  output logic                               arready_o,
  output noc_axi_pkg::axi_r_t                r_o,
  input  logic                               rready_i,
  input  logic [noc_axi_pkg::N_VIRT_CHN-1:0] vc_empty_i,
  input  noc_axi_pkg::axi_data_t             flit_i,
  output noc_axi_pkg::vc_id_t                sel_vc_o,
  output logic                               pop_o
);
  noc_axi_pkg::rd_req_t  req_in;
  noc_axi_pkg::rd_req_t  req_head;
  noc_axi_pkg::vc_id_t   ar_vc;
  noc_axi_pkg::axi_len_t beat_q;
  logic                  q_full;
  logic                  q_empty;
  logic                  ar_hs;
  logic                  r_hs;
  logic                  retire;
  logic                  active_q;

  // **************************************************
  // Request check and queue
  // **************************************************
  assign ar_vc     = noc_axi_pkg::addr_vc(ar_i.addr);
  assign arready_o = !q_full;
  assign ar_hs     = ar_i.valid && arready_o;

  always_comb begin
    req_in.id  = ar_i.id;
    req_in.vc  = ar_vc;
    req_in.len = ar_i.len;
    // Reading an empty channel counts as an error too
    req_in.err = (ar_i.burst != noc_axi_pkg::INCR) ||
                 (ar_i.size != noc_axi_pkg::FULL_SIZE) ||
                 (noc_axi_pkg::addr_region(ar_i.addr) != noc_axi_pkg::NOC_RD_FIFOS) ||
                 vc_empty_i[ar_vc];
  end

  sync_fifo #(
    .SLOTS (noc_axi_pkg::MAX_OUTSTD_RD),
    .WIDTH ($bits(noc_axi_pkg::rd_req_t))
  ) u_rd_req_fifo (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .write_i  (ar_hs),
    .read_i   (retire),
    .data_i   (req_in),
    .data_o   (req_head),
    .full_o   (q_full),
    .empty_o  (q_empty)
  );

  // **************************************************
  // R beat generation
  // **************************************************
  always_comb begin
    r_o.id    = req_head.id;
    // Beats only once the head request has settled for a cycle
    r_o.valid = active_q && (req_head.err || !vc_empty_i[req_head.vc]);
    r_o.data  = req_head.err ? '0 : flit_i;
    r_o.resp  = req_head.err ? noc_axi_pkg::SLVERR : noc_axi_pkg::OKAY;
    r_o.last  = r_o.valid && (req_head.err || (beat_q == req_head.len));
  end

  assign r_hs     = r_o.valid && rready_i;
  assign retire   = r_hs && r_o.last;
  assign sel_vc_o = req_head.vc;
  // Error beats take nothing from the buffers
  assign pop_o    = r_hs && !req_head.err;

  // Beat counter and head activity flag
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      beat_q   <= '0;
      active_q <= 1'b0;
    end else begin
      if (retire)
        beat_q <= '0;
      else if (r_hs)
        beat_q <= beat_q + 1'b1;
      // Drops for one cycle after each retire so the next head settles
      active_q <= retire ? 1'b0 : !q_empty;
    end
  end

endmodule

/* hw/noc_axi_slave.sv */
/*
  AXI slave front end of a NoC node, write path and read path side by side
  The network input fills per-channel buffers drained by AXI reads
  AXI writes become flits towards the packet generator
*/
module noc_axi_slave (
  input  logic                  clk_axi,
  input  logic                  arst_axi,
  // AXI slave port
  input  noc_axi_pkg::axi_aw_t  aw_i,
  output logic                  awready_o,
  input  noc_axi_pkg::axi_w_t   w_i,
  output logic                  wready_o,
  output noc_axi_pkg::axi_b_t   b_o,
  input  logic                  bready_i,
  input  noc_axi_pkg::axi_ar_t  ar_i,
  output logic                  arready_o,
  output noc_axi_pkg::axi_r_t   r_o,
  input  logic                  rready_i,
  // Network side
  input  noc_axi_pkg::pkt_in_t  pkt_in_i,
  output logic                  pkt_in_ready_o,
  output noc_axi_pkg::pkt_out_t pkt_out_o,
  input  logic                  pkt_out_ready_i
);
  logic [noc_axi_pkg::N_VIRT_CHN-1:0] vc_empty;
  noc_axi_pkg::vc_id_t                sel_vc;
  noc_axi_pkg::axi_data_t             flit;
  logic                               pop;

  // **************************************************
  // Write path
  // **************************************************
  axi_wr_path u_axi_wr_path (
    .clk_axi         (clk_axi),
    .arst_axi        (arst_axi),
    .aw_i            (aw_i),
    .awready_o       (awready_o),
    .w_i             (w_i),
    .wready_o        (wready_o),
    .b_o             (b_o),
    .bready_i        (bready_i),
    .pkt_out_o       (pkt_out_o),
    .pkt_out_ready_i (pkt_out_ready_i)
  );

  // **************************************************
  // Receive buffers and read path
  // **************************************************
  rx_vc_buffers u_rx_vc_buffers (
    .clk_axi        (clk_axi),
    .arst_axi       (arst_axi),
    .pkt_in_i       (pkt_in_i),
    .pkt_in_ready_o (pkt_in_ready_o),
    .sel_vc_i       (sel_vc),
    .pop_i          (pop),
    .flit_o         (flit),
    .empty_o        (vc_empty)
  );

  axi_rd_path u_axi_rd_path (
    .clk_axi    (clk_axi),
    .arst_axi   (arst_axi),
    .ar_i       (ar_i),
    .arready_o  (arready_o),
    .r_o        (r_o),
    .rready_i   (rready_i),
    .vc_empty_i (vc_empty),
    .flit_i     (flit),
    .sel_vc_o   (sel_vc),
    .pop_o      (pop)
  );

endmodule

/* tb/noc_axi_slave_props.sv */
/*
  Handshake properties for two valid/ready streams and a last-beat gap
  Bound into the write path (B and flits) and into the read path (R)
  Unused stream inputs are tied off in the bind
*/
module noc_axi_slave_props #(
  parameter int W0 = 1,
  parameter int W1 = 1
) (
  input logic          clk_axi,
  input logic          arst_axi,
  input logic          valid0_i,
  input logic          ready0_i,
  input logic [W0-1:0] data0_i,
  input logic          valid1_i,
  input logic          ready1_i,
  input logic [W1-1:0] data1_i,
  input logic          last_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Count of failed assertions
  int fails;

  initial fails = 0;

  // A stalled transfer keeps valid and payload
  assert property (@(posedge clk_axi) disable iff (arst_axi)
    (valid0_i && !ready0_i) |=> (valid0_i && $stable(data0_i)))
    else begin
      $error("stream 0 changed while stalled");
      fails++;
    end

  assert property (@(posedge clk_axi) disable iff (arst_axi)
    (valid1_i && !ready1_i) |=> (valid1_i && $stable(data1_i)))
    else begin
      $error("stream 1 changed while stalled");
      fails++;
    end

  // After a last beat the next request settles for a cycle
  assert property (@(posedge clk_axi) disable iff (arst_axi)
    (valid0_i && ready0_i && last_i) |=> !valid0_i)
    else begin
      $error("valid right after the last beat");
      fails++;
    end

endmodule

/* tb/axi_slave_checker.sv */
/*
  Reference model of the NoC AXI slave, sampled on rising clock edges
  Keeps one flit queue per channel from observed network-input handshakes
  Predicts flits, B and R beats, the ready outputs and the network input ready
*/
module axi_slave_checker (
  input  logic                  clk_axi,
  input  logic                  arst_axi,
  input  noc_axi_pkg::axi_aw_t  aw_i,
  input  logic                  awready_o,
  input  noc_axi_pkg::axi_w_t   w_i,
  input  logic                  wready_o,
  input  noc_axi_pkg::axi_b_t   b_o,
  input  logic                  bready_i,
  input  noc_axi_pkg::axi_ar_t  ar_i,
  input  logic                  arready_o,
  input  noc_axi_pkg::axi_r_t   r_o,
  input  logic                  rready_i,
  input  noc_axi_pkg::pkt_in_t  pkt_in_i,
  input  logic                  pkt_in_ready_o,
  input  noc_axi_pkg::pkt_out_t pkt_out_o,
  input  logic                  pkt_out_ready_i,
  output int                    value_errs,
  output int                    proto_errs,
  output int                    rd_pending
);
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [3:0] id;
    logic [1:0] vc;
    logic [7:0] len;
    logic       err;
  } exp_rd_t;

  logic [63:0] flit_q [3][$];
  exp_rd_t     rd_q [$];
  int          rd_beat;
  logic        wr_busy;
  logic        wr_data;
  logic        wr_err;
  logic [3:0]  wr_id;
  logic [1:0]  wr_vc;
  logic [7:0]  wr_len;
  int          wr_beats;

  // Slot k of a window lies at base + 8k, three slots per window
  function automatic bit in_window(logic [15:0] addr, logic [15:0] base);
    return (addr >= base) && (addr < base + 16'd24) && (addr[2:0] == 3'b000);
  endfunction

  task automatic compare(string name, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic report(string msg);
    $display("Protocol error at %0t: %s", $time, msg);
    proto_errs++;
  endtask

  // **************************************************
  // Per-edge model update
  // **************************************************
  always @(posedge clk_axi or posedge arst_axi) begin
    logic    push;
    exp_rd_t ar_e;
    exp_rd_t h;
    logic    last_exp;
    if (arst_axi) begin
      for (int i = 0; i < 3; i++)
        flit_q[i].delete();
      rd_q.delete();
      rd_beat  = 0;
      wr_busy  = 1'b0;
      wr_data  = 1'b0;
      wr_beats = 0;
      rd_pending = 0;
    end else begin
      // Ready and response valid, predicted from the transaction state
      compare("awready_o", 64'(!wr_busy), 64'(awready_o));
      compare("wready_o", 64'(wr_data && (wr_err || pkt_out_ready_i)), 64'(wready_o));
      compare("b_o.valid", 64'(wr_busy && !wr_data), 64'(b_o.valid));
      compare("arready_o", 64'(rd_q.size() < 4), 64'(arready_o));

      // Network input, ready is low only on a full or missing channel
      push = 1'b0;
      if (pkt_in_i.valid) begin
        compare("pkt_in_ready_o", 64'((pkt_in_i.vc < 2'd3) &&
                (flit_q[pkt_in_i.vc].size() < 8)), 64'(pkt_in_ready_o));
        push = pkt_in_ready_o && (pkt_in_i.vc < 2'd3);
      end
      // Read request judged on the channel state before this edge
      ar_e.id  = ar_i.id;
      ar_e.len = ar_i.len;
      ar_e.vc  = 2'((ar_i.addr - 16'h2000) >> 3);
      ar_e.err = (ar_i.burst != noc_axi_pkg::INCR) || (ar_i.size != 3'd3) ||
                 !in_window(ar_i.addr, 16'h2000);
      if (!ar_e.err && flit_q[ar_e.vc].size() == 0)
        ar_e.err = 1'b1;

      // Flits towards the packet generator
      if (pkt_out_o.valid && (!wr_busy || wr_err))
        report("flit sent without an accepted error-free write");
      else if (pkt_out_o.valid && pkt_out_ready_i) begin
        compare("pkt_out_o.vc", 64'(wr_vc), 64'(pkt_out_o.vc));
        compare("pkt_out_o.req_new", 64'(wr_beats == 0), 64'(pkt_out_o.req_new));
        compare("pkt_out_o.req_last", 64'(wr_beats == int'(wr_len)),
                64'(pkt_out_o.req_last));
        compare("pkt_out_o.pkt_sz", 64'(wr_len) + 64'd1, 64'(pkt_out_o.pkt_sz));
        compare("pkt_out_o.data", w_i.data, pkt_out_o.data);
        wr_beats++;
      end

      // Data phase ends with the wlast handshake
      if (w_i.valid && wready_o && w_i.last)
        wr_data = 1'b0;

      // Write response after the whole burst
      if (b_o.valid && !wr_busy)
        report("bvalid without a pending write");
      else if (b_o.valid && bready_i) begin
        compare("b_o.id", 64'(wr_id), 64'(b_o.id));
        compare("b_o.resp", wr_err ? 64'h2 : 64'h0, 64'(b_o.resp));
        compare("flit count", wr_err ? 64'd0 : 64'(wr_len) + 64'd1, 64'(wr_beats));
        wr_busy = 1'b0;
      end

      if (aw_i.valid && awready_o) begin
        if (wr_busy)
          report("AW accepted while a write was pending");
        wr_busy  = 1'b1;
        wr_data  = 1'b1;
        wr_id    = aw_i.id;
        wr_len   = aw_i.len;
        wr_vc    = 2'((aw_i.addr - 16'h1000) >> 3);
        wr_err   = (aw_i.burst != noc_axi_pkg::INCR) || (aw_i.size != 3'd3) ||
                   !in_window(aw_i.addr, 16'h1000);
        wr_beats = 0;
      end

      // Read data in request order
      if (r_o.valid && rready_i) begin
        if (rd_q.size() == 0)
          report("R beat without a queued read");
        else begin
          h = rd_q[0];
          compare("r_o.id", 64'(h.id), 64'(r_o.id));
          if (h.err) begin
            compare("r_o.data", 64'h0, r_o.data);
            compare("r_o.resp", 64'h2, 64'(r_o.resp));
            compare("r_o.last", 64'h1, 64'(r_o.last));
            void'(rd_q.pop_front());
            rd_beat = 0;
          end else if (flit_q[h.vc].size() == 0)
            report("R beat from a channel the model holds empty");
          else begin
            last_exp = (rd_beat == int'(h.len));
            compare("r_o.data", flit_q[h.vc].pop_front(), r_o.data);
            compare("r_o.resp", 64'h0, 64'(r_o.resp));
            compare("r_o.last", 64'(last_exp), 64'(r_o.last));
            rd_beat++;
            if (last_exp) begin
              void'(rd_q.pop_front());
              rd_beat = 0;
            end
          end
        end
      end

      if (push)
        flit_q[pkt_in_i.vc].push_back(pkt_in_i.data);
      if (ar_i.valid && arready_o)
        rd_q.push_back(ar_e);
      rd_pending = rd_q.size();
    end
  end

  initial begin
    value_errs = 0;
    proto_errs = 0;
  end

endmodule

/* tb/tb_noc_axi_slave.sv */
/*
  Testbench of the NoC AXI slave, acting as AXI master, network and generator
  Operations come from tb/noc_axi_slave_tests.txt, run from the project root
  Reads return after AR, their beats are drained by a free-running rready
*/
module tb_noc_axi_slave;
  timeunit 1ns;
  timeprecision 100ps;

  logic                  clk_axi;
  logic                  arst_axi;
  noc_axi_pkg::axi_aw_t  aw_i;
  logic                  awready_o;
  noc_axi_pkg::axi_w_t   w_i;
  logic                  wready_o;
  noc_axi_pkg::axi_b_t   b_o;
  logic                  bready_i;
  noc_axi_pkg::axi_ar_t  ar_i;
  logic                  arready_o;
  noc_axi_pkg::axi_r_t   r_o;
  logic                  rready_i;
  noc_axi_pkg::pkt_in_t  pkt_in_i;
  logic                  pkt_in_ready_o;
  noc_axi_pkg::pkt_out_t pkt_out_o;
  logic                  pkt_out_ready_i;
  int                    value_errs;
  int                    proto_errs;
  int                    rd_pending;
  int                    assert_errs;
  int                    load_errs;
  int                    cycles;
  int                    limit;

  noc_axi_slave UUT (.*);

  axi_slave_checker u_checker (.*);

  bind axi_wr_path noc_axi_slave_props #(
    .W0 ($bits(noc_axi_pkg::axi_b_t)),
    .W1 ($bits(noc_axi_pkg::pkt_out_t))
  ) u_wr_props (
    .clk_axi (clk_axi), .arst_axi (arst_axi),
    .valid0_i (b_o.valid), .ready0_i (bready_i), .data0_i (b_o),
    .valid1_i (pkt_out_o.valid), .ready1_i (pkt_out_ready_i), .data1_i (pkt_out_o),
    .last_i (1'b0)
  );

  bind axi_rd_path noc_axi_slave_props #(
    .W0 ($bits(noc_axi_pkg::axi_r_t)),
    .W1 (1)
  ) u_rd_props (
    .clk_axi (clk_axi), .arst_axi (arst_axi),
    .valid0_i (r_o.valid), .ready0_i (rready_i), .data0_i (r_o),
    .valid1_i (1'b0), .ready1_i (1'b1), .data1_i (1'b0),
    .last_i (r_o.last)
  );

  // **************************************************
  // Clock, random back-pressure, timeout
  // **************************************************
  always #50 clk_axi = !clk_axi;

  always @(negedge clk_axi) begin
    rready_i        = ($urandom_range(3) != 0);
    pkt_out_ready_i = ($urandom_range(3) != 0);
  end

  always @(posedge clk_axi) begin
    if (!arst_axi && limit > 0) begin
      cycles++;
      if (cycles > limit) begin
        $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
        $display("Simulation failed");
        $finish;
      end
    end
  end

  // **************************************************
  // Bus tasks, all start and end on a falling edge
  // **************************************************
  // Ready is sampled once the inputs have settled, handshake at the next rise
  task automatic inject(logic [1:0] vc, logic [63:0] data);
    bit hs;
    pkt_in_i.vc    = vc;
    pkt_in_i.data  = data;
    pkt_in_i.valid = 1'b1;
    do begin
      #1;
      hs = pkt_in_ready_o;
      @(negedge clk_axi);
    end while (!hs);
    pkt_in_i.valid = 1'b0;
  endtask

  task automatic write_burst(logic [3:0] id, logic [15:0] addr, logic [7:0] len,
                             logic [1:0] burst, logic [2:0] size, logic [63:0] data);
    bit hs;
    aw_i.id    = id;
    aw_i.addr  = addr;
    aw_i.len   = len;
    aw_i.size  = size;
    aw_i.burst = noc_axi_pkg::burst_t'(burst);
    aw_i.valid = 1'b1;
    do begin
      #1;
      hs = awready_o;
      @(negedge clk_axi);
    end while (!hs);
    aw_i.valid = 1'b0;
    // Incrementing data, one beat per len step
    for (int i = 0; i <= int'(len); i++) begin
      w_i.data  = data + 64'(i);
      w_i.last  = (i == int'(len));
      w_i.valid = 1'b1;
      do begin
        #1;
        hs = wready_o;
        @(negedge clk_axi);
      end while (!hs);
    end
    w_i.valid = 1'b0;
    w_i.last  = 1'b0;
    repeat ($urandom_range(2)) @(negedge clk_axi);
    bready_i = 1'b1;
    do begin
      #1;
      hs = b_o.valid;
      @(negedge clk_axi);
    end while (!hs);
    bready_i = 1'b0;
  endtask

  task automatic read_request(logic [3:0] id, logic [15:0] addr, logic [7:0] len,
                              logic [1:0] burst, logic [2:0] size);
    bit hs;
    ar_i.id    = id;
    ar_i.addr  = addr;
    ar_i.len   = len;
    ar_i.size  = size;
    ar_i.burst = noc_axi_pkg::burst_t'(burst);
    ar_i.valid = 1'b1;
    do begin
      #1;
      hs = arready_o;
      @(negedge clk_axi);
    end while (!hs);
    ar_i.valid = 1'b0;
  endtask

  // **************************************************
  // Main sequence
  // **************************************************
  initial begin
    int          fd;
    string       line;
    string       lines [$];
    string       op;
    logic [63:0] a [5];
    clk_axi         = 1'b0;
    arst_axi        = 1'b1;
    aw_i            = '0;
    w_i             = '0;
    ar_i            = '0;
    pkt_in_i        = '0;
    bready_i        = 1'b0;
    rready_i        = 1'b0;
    pkt_out_ready_i = 1'b0;
    assert_errs     = 0;
    load_errs       = 0;
    cycles          = 0;
    limit           = 0;
    void'($urandom(32'hf9db));

    fd = $fopen("tb/noc_axi_slave_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file tb/noc_axi_slave_tests.txt");
      load_errs++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 1 && line[0] != "#")
          lines.push_back(line);
      end
      $fclose(fd);
    end
    limit = 30 * lines.size() + 100;

    repeat (4) @(posedge clk_axi);
    @(negedge clk_axi);
    arst_axi = 1'b0;
    @(negedge clk_axi);

    foreach (lines[n]) begin
      a = '{default: '0};
      void'($sscanf(lines[n], "%s %h %h %h %h %h", op, a[0], a[1], a[2], a[3], a[4]));
      if (op == "INJ")
        inject(a[0][1:0], a[1]);
      else if (op == "WR")
        write_burst(4'(n), a[0][15:0], a[1][7:0], a[2][1:0], a[3][2:0], a[4]);
      else if (op == "RD")
        read_request(4'(n), a[0][15:0], a[1][7:0], a[2][1:0], a[3][2:0]);
      else begin
        $display("Unknown operation in test line %0d", n);
        load_errs++;
      end
    end

    // Let queued reads finish
    while (rd_pending != 0)
      @(negedge clk_axi);
    repeat (2) @(negedge clk_axi);

    assert_errs = UUT.u_axi_wr_path.u_wr_props.fails + UUT.u_axi_rd_path.u_rd_props.fails;
    $display("Errors: %0d value, %0d protocol, %0d assertion, %0d test file", value_errs,
             proto_errs, assert_errs, load_errs);
    if (value_errs + proto_errs + assert_errs + load_errs == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* tb/noc_axi_slave_tests.txt */
# INJ vc data | WR addr len burst size data | RD addr len burst size
# all fields hex, burst 0 FIXED 1 INCR 2 WRAP, size 3 is full width
RD 2000 0 1 3
WR 1000 3 1 3 a000000000000000
WR 1010 7 1 3 b000000000000000
WR 1008 0 1 3 c000000000000000
WR 1018 1 1 3 d0
WR 0040 0 1 3 e0
WR 1000 1 0 3 f0
WR 1008 1 1 2 f1
RD 2018 0 1 3
RD 2004 0 1 3
INJ 0 11
INJ 1 21
INJ 0 12
INJ 0 13
RD 2000 2 1 3
RD 2008 0 1 3
RD 2010 0 2 3
INJ 2 31
INJ 2 32
INJ 2 33
INJ 2 34
INJ 2 35
INJ 2 36
INJ 2 37
INJ 2 38
RD 2010 3 1 3
INJ 2 39
RD 2010 4 1 3
RD 2008 0 1 1

/* sim.f */
hw/noc_axi_pkg.sv
hw/sync_fifo.sv
hw/axi_wr_path.sv
hw/rx_vc_buffers.sv
hw/axi_rd_path.sv
hw/noc_axi_slave.sv
tb/noc_axi_slave_props.sv
tb/axi_slave_checker.sv
tb/tb_noc_axi_slave.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -j 0
TOP       := tb_noc_axi_slave
FILELIST  := sim.f
LOG       := sim.log
OBJDIR    := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
